// ==== decode_pkg.sv ====
package decode_pkg;

    // fetched instruction word
    typedef logic [31:0] inst_t;
    // register value or sign-extended immediate
    typedef logic [31:0] xword_t;
    // register number x0..x31
    typedef logic [4:0]  reg_adr_t;
    // funct3 field, handed to the alu as is
    typedef logic [2:0]  alu_code_t;

    // command flags, one bit per command
    localparam int CMD_W = 22;
    typedef logic [CMD_W-1:0] cmd_vec_t;

    // bit positions inside cmd_vec_t
    localparam int CMD_LUI        = 0;
    localparam int CMD_AUIPC      = 1;
    localparam int CMD_LD         = 2;
    localparam int CMD_ALUI       = 3;
    localparam int CMD_ALUI_SHAMT = 4;
    localparam int CMD_ALU        = 5;
    localparam int CMD_ST         = 6;
    localparam int CMD_JAL        = 7;
    localparam int CMD_JALR       = 8;
    localparam int CMD_BR         = 9;
    localparam int CMD_FENCE      = 10;
    localparam int CMD_FENCEI     = 11;
    localparam int CMD_SFENCE     = 12;
    localparam int CMD_CSR        = 13;
    localparam int CMD_ECALL      = 14;
    localparam int CMD_EBREAK     = 15;
    localparam int CMD_URET       = 16;
    localparam int CMD_SRET       = 17;
    localparam int CMD_MRET       = 18;
    localparam int CMD_WFI        = 19;
    localparam int CMD_ILLEGAL    = 20;
    // addi x0,x0,0 only, kept apart from CMD_ALUI
    localparam int CMD_NOP        = 21;

    // major opcodes, inst[6:2]
    localparam logic [4:0] OP_LUI    = 5'b01101;
    localparam logic [4:0] OP_AUIPC  = 5'b00101;
    localparam logic [4:0] OP_JAL    = 5'b11011;
    localparam logic [4:0] OP_JALR   = 5'b11001;
    localparam logic [4:0] OP_BRANCH = 5'b11000;
    localparam logic [4:0] OP_LOAD   = 5'b00000;
    localparam logic [4:0] OP_STORE  = 5'b01000;
    localparam logic [4:0] OP_ALUI   = 5'b00100;
    localparam logic [4:0] OP_ALU    = 5'b01100;
    localparam logic [4:0] OP_FENCE  = 5'b00011;
    localparam logic [4:0] OP_SYSTEM = 5'b11100;

endpackage

// ==== decoder.sv ====
`timescale 1ns/1ns

module decoder
    import decode_pkg::*;
(
    input  inst_t     inst,
    output cmd_vec_t  cmd,
    output alu_code_t alu_code,
    output logic      alu_sub,
    output xword_t    imm,
    output reg_adr_t  rs1_adr,
    output reg_adr_t  rs2_adr,
    output reg_adr_t  rd_adr,
    output logic      rd_we,
    output logic      rs1_used,
    output logic      rs2_used
);

    // canonical nop (addi x0,x0,0)
    localparam inst_t NOP_WORD = 32'h0000_0013;

    // one-hot of the supported major opcodes
    function automatic logic [10:0] op_decode(input logic [4:0] op);
        logic [10:0] oh;
        oh = '0;
        case (op)
            OP_LUI:    oh[0]  = 1'b1;
            OP_AUIPC:  oh[1]  = 1'b1;
            OP_JAL:    oh[2]  = 1'b1;
            OP_JALR:   oh[3]  = 1'b1;
            OP_BRANCH: oh[4]  = 1'b1;
            OP_LOAD:   oh[5]  = 1'b1;
            OP_STORE:  oh[6]  = 1'b1;
            OP_ALUI:   oh[7]  = 1'b1;
            OP_ALU:    oh[8]  = 1'b1;
            OP_FENCE:  oh[9]  = 1'b1;
            OP_SYSTEM: oh[10] = 1'b1;
            default:   oh     = '0;
        endcase
        return oh;
    endfunction

    // funct7 patterns that some command accepts
    function automatic logic [4:0] f7_decode(input logic [6:0] f7);
        logic [4:0] oh;
        oh = '0;
        case (f7)
            7'b0000000: oh[0] = 1'b1;
            // sub, sra, srai
            7'b0100000: oh[1] = 1'b1;
            // sret, wfi
            7'b0001000: oh[2] = 1'b1;
            // mret
            7'b0011000: oh[3] = 1'b1;
            // sfence.vma
            7'b0001001: oh[4] = 1'b1;
            default:    oh    = '0;
        endcase
        return oh;
    endfunction

    // system sub-op lives in the rs2 field
    function automatic logic [3:0] sub_decode(input logic [4:0] sub);
        logic [3:0] oh;
        oh = '0;
        case (sub)
            5'b00000: oh[0] = 1'b1;
            5'b00001: oh[1] = 1'b1;
            5'b00010: oh[2] = 1'b1;
            5'b00101: oh[3] = 1'b1;
            default:  oh    = '0;
        endcase
        return oh;
    endfunction

    logic [10:0] dc_op;
    logic [7:0]  dc_f3;
    logic [4:0]  dc_f7;
    logic [3:0]  dc_sub;
    logic        notc;
    logic        z_rd;
    logic        z_rs1;
    logic        z_fm;
    logic        z_imm12;
    logic        shift_ok;
    logic        sys_base;
    logic        c_lui, c_auipc, c_jal, c_jalr, c_br, c_ld, c_st;
    logic        c_alui, c_shamt, c_alu, c_nop;
    logic        c_fence, c_fencei, c_sfence, c_csr;
    logic        c_ecall, c_ebreak, c_uret, c_sret, c_mret, c_wfi;
    xword_t      imm_i, imm_s, imm_b, imm_j, imm_u;

    // field slices
    assign rd_adr   = inst[11:7];
    assign rs1_adr  = inst[19:15];
    assign rs2_adr  = inst[24:20];
    assign alu_code = inst[14:12];

    assign dc_op  = op_decode(inst[6:2]);
    assign dc_f3  = 8'b0000_0001 << inst[14:12];
    assign dc_f7  = f7_decode(inst[31:25]);
    assign dc_sub = sub_decode(inst[24:20]);

    // low bits 11 mark a 32-bit encoding
    assign notc    = (inst[1:0] == 2'b11);
    assign z_rd    = (inst[11:7] == 5'd0);
    assign z_rs1   = (inst[19:15] == 5'd0);
    // fence fm field
    assign z_fm    = (inst[31:28] == 4'd0);
    assign z_imm12 = (inst[31:20] == 12'd0);

    assign c_lui   = notc & dc_op[0];
    assign c_auipc = notc & dc_op[1];
    assign c_jal   = notc & dc_op[2];
    assign c_jalr  = notc & dc_op[3] & dc_f3[0];
    // funct3 010 and 011 are reserved for branches
    assign c_br    = notc & dc_op[4] & ~(dc_f3[2] | dc_f3[3]);
    // lb lh lw lbu lhu
    assign c_ld    = notc & dc_op[5] & (dc_f3[0] | dc_f3[1] | dc_f3[2] | dc_f3[4] | dc_f3[5]);
    // sb sh sw
    assign c_st    = notc & dc_op[6] & (dc_f3[0] | dc_f3[1] | dc_f3[2]);

    assign c_nop    = (inst == NOP_WORD);
    assign c_alui   = notc & dc_op[7] & ~(dc_f3[1] | dc_f3[5]) & ~c_nop;
    // slli needs funct7 zero while srli/srai allow bit 30
    assign shift_ok = (dc_f3[1] & dc_f7[0]) | (dc_f3[5] & (dc_f7[0] | dc_f7[1]));
    assign c_shamt  = notc & dc_op[7] & shift_ok;
    // bit 30 only legal for sub and sra
    assign c_alu    = notc & dc_op[8] & (dc_f7[0] | (dc_f7[1] & (dc_f3[0] | dc_f3[5])));

    assign c_fence  = notc & dc_op[9] & dc_f3[0] & z_fm & z_rs1 & z_rd;
    // fence.i has the whole immediate zero
    assign c_fencei = notc & dc_op[9] & dc_f3[1] & z_imm12 & z_rs1 & z_rd;

    assign c_sfence = notc & dc_op[10] & dc_f3[0] & dc_f7[4] & z_rd;
    // funct3 100 is unused in system space
    assign c_csr    = notc & dc_op[10] & ~dc_f3[0] & ~dc_f3[4];

    // privileged group shares rs1/rd zero and funct3 000
    assign sys_base = notc & dc_op[10] & dc_f3[0] & z_rs1 & z_rd;
    assign c_ecall  = sys_base & dc_f7[0] & dc_sub[0];
    assign c_ebreak = sys_base & dc_f7[0] & dc_sub[1];
    assign c_uret   = sys_base & dc_f7[0] & dc_sub[2];
    assign c_sret   = sys_base & dc_f7[2] & dc_sub[2];
    assign c_mret   = sys_base & dc_f7[3] & dc_sub[2];
    assign c_wfi    = sys_base & dc_f7[2] & dc_sub[3];

    always_comb
    begin
        cmd                 = '0;
        cmd[CMD_LUI]        = c_lui;
        cmd[CMD_AUIPC]      = c_auipc;
        cmd[CMD_LD]         = c_ld;
        cmd[CMD_ALUI]       = c_alui;
        cmd[CMD_ALUI_SHAMT] = c_shamt;
        cmd[CMD_ALU]        = c_alu;
        cmd[CMD_ST]         = c_st;
        cmd[CMD_JAL]        = c_jal;
        cmd[CMD_JALR]       = c_jalr;
        cmd[CMD_BR]         = c_br;
        cmd[CMD_FENCE]      = c_fence;
        cmd[CMD_FENCEI]     = c_fencei;
        cmd[CMD_SFENCE]     = c_sfence;
        cmd[CMD_CSR]        = c_csr;
        cmd[CMD_ECALL]      = c_ecall;
        cmd[CMD_EBREAK]     = c_ebreak;
        cmd[CMD_URET]       = c_uret;
        cmd[CMD_SRET]       = c_sret;
        cmd[CMD_MRET]       = c_mret;
        cmd[CMD_WFI]        = c_wfi;
        cmd[CMD_NOP]        = c_nop;
        // nothing matched
        cmd[CMD_ILLEGAL]    = ~|cmd;
    end

    // immediate formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};

    // shifts keep I format and execute takes shamt from imm[4:0]
    always_comb
    begin
        if (c_ld | c_alui | c_shamt | c_jalr | c_csr)
            imm = imm_i;
        else if (c_st)
            imm = imm_s;
        else if (c_br)
            imm = imm_b;
        else if (c_jal)
            imm = imm_j;
        else if (c_lui | c_auipc)
            imm = imm_u;
        else
            imm = '0;
    end

    // only register alu ops use bit 30 as sub/sra select
    assign alu_sub = c_alu & inst[30];

    // nop keeps rd_we since its write to x0 is dropped anyway
    assign rd_we = c_lui | c_auipc | c_ld | c_alui | c_shamt | c_alu
                 | c_jal | c_jalr | c_csr | c_nop;

    // operand use for the load-use check
    // csr immediate forms (funct3 1xx) read no register
    assign rs1_used = c_ld | c_st | c_alui | c_shamt | c_alu | c_jalr | c_br
                    | c_sfence | (c_csr & ~inst[14]);
    assign rs2_used = c_alu | c_st | c_br | c_sfence;

    // exactly one command per word including illegal
    a_cmd_onehot: assert final ($onehot(cmd));

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ns

module reg_file
    import decode_pkg::*;
#(
    // 1 forwards a same-cycle write to the read ports
    parameter int WRITE_BYPASS = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_adr_t rs1_adr,
    input  reg_adr_t rs2_adr,
    input  logic     we,
    input  reg_adr_t wr_adr,
    input  xword_t   wr_data,
    output xword_t   rs1_data,
    output xword_t   rs2_data
);

    // storage for x1..x31 only since x0 has none
    xword_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        // writes to x0 dropped
        else if (we && (wr_adr != '0))
        begin
            regs[wr_adr] <= wr_data;
        end
    end

    // one read port checks x0 first, then the bypass, then storage
    function automatic xword_t read_port(input reg_adr_t adr);
        if (adr == '0)
            return '0;
        else if ((WRITE_BYPASS != 0) && we && (adr == wr_adr))
            return wr_data;
        else
            return regs[adr];
    endfunction

    always_comb
    begin
        rs1_data = read_port(rs1_adr);
        rs2_data = read_port(rs2_adr);
    end

    // a stored value reads back on the next edge unless that register is rewritten
    a_read_back: assert property (@(posedge clk) disable iff (!rst_n)
        (we && (wr_adr != '0)) |=> ((rs1_adr != $past(wr_adr))
            || (we && (wr_adr == rs1_adr)) || (rs1_data == $past(wr_data))));

endmodule

// ==== id_ex_reg.sv ====
`timescale 1ns/1ns

module id_ex_reg
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      inst_valid,
    input  cmd_vec_t  cmd,
    input  alu_code_t alu_code,
    input  logic      alu_sub,
    input  xword_t    imm,
    input  reg_adr_t  rd_adr,
    input  logic      rd_we,
    input  reg_adr_t  rs1_adr,
    input  reg_adr_t  rs2_adr,
    input  logic      rs1_used,
    input  logic      rs2_used,
    input  xword_t    rs1_data,
    input  xword_t    rs2_data,
    output logic      stall,
    output logic      ex_valid,
    output cmd_vec_t  ex_cmd,
    output alu_code_t ex_alu_code,
    output logic      ex_alu_sub,
    output xword_t    ex_imm,
    output xword_t    ex_rs1_data,
    output xword_t    ex_rs2_data,
    output reg_adr_t  ex_rd_adr,
    output logic      ex_rd_we
);

    logic held_load;
    logic rs1_hit;
    logic rs2_hit;
    logic issue;

    // load sitting in execute that writes a real register
    assign held_load = ex_valid & ex_cmd[CMD_LD] & (ex_rd_adr != '0);

    // decoded sources against the load target
    assign rs1_hit = rs1_used & (rs1_adr == ex_rd_adr);
    assign rs2_hit = rs2_used & (rs2_adr == ex_rd_adr);

    // load data is not ready until after execute so fetch holds one cycle
    assign stall = inst_valid & held_load & (rs1_hit | rs2_hit);

    // word goes to execute this edge
    assign issue = inst_valid & ~stall;

    // control part is cleared on reset and on a bubble
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ex_valid  <= 1'b0;
            ex_cmd    <= '0;
            ex_rd_we  <= 1'b0;
            ex_rd_adr <= '0;
        end
        else
        begin
            ex_valid  <= issue;
            // bubble carries no command
            ex_cmd    <= issue ? cmd : '0;
            ex_rd_we  <= issue & rd_we;
            // hazard compare is qualified by ex_valid
            ex_rd_adr <= rd_adr;
        end
    end

    // operand payload for execute
    always_ff @(posedge clk)
    begin
        ex_alu_code <= alu_code;
        ex_alu_sub  <= alu_sub;
        ex_imm      <= imm;
        ex_rs1_data <= rs1_data;
        ex_rs2_data <= rs2_data;
    end

    // hazard detection relies on every held load writing its rd
    a_load_writes_rd: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_valid && ex_cmd[CMD_LD]) |-> ex_rd_we);

    // a valid slot carries exactly one command
    a_valid_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid |-> $onehot(ex_cmd));

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage
    import decode_pkg::*;
#(
    parameter int WRITE_BYPASS = 1
) (
    input  logic      clk,
    input  logic      rst_n,
    // from fetch
    input  inst_t     inst,
    input  logic      inst_valid,
    // writeback port
    input  logic      wb_we,
    input  reg_adr_t  wb_adr,
    input  xword_t    wb_data,
    // back to fetch
    output logic      stall,
    // to execute
    output logic      ex_valid,
    output cmd_vec_t  ex_cmd,
    output alu_code_t ex_alu_code,
    output logic      ex_alu_sub,
    output xword_t    ex_imm,
    output xword_t    ex_rs1_data,
    output xword_t    ex_rs2_data,
    output reg_adr_t  ex_rd_adr,
    output logic      ex_rd_we
);

    cmd_vec_t  cmd;
    alu_code_t alu_code;
    logic      alu_sub;
    xword_t    imm;
    reg_adr_t  rs1_adr;
    reg_adr_t  rs2_adr;
    reg_adr_t  rd_adr;
    logic      rd_we;
    logic      rs1_used;
    logic      rs2_used;
    xword_t    rs1_data;
    xword_t    rs2_data;

    decoder u_decoder (
        .inst     (inst),
        .cmd      (cmd),
        .alu_code (alu_code),
        .alu_sub  (alu_sub),
        .imm      (imm),
        .rs1_adr  (rs1_adr),
        .rs2_adr  (rs2_adr),
        .rd_adr   (rd_adr),
        .rd_we    (rd_we),
        .rs1_used (rs1_used),
        .rs2_used (rs2_used)
    );

    // reads in parallel with the decode
    reg_file #(
        .WRITE_BYPASS (WRITE_BYPASS)
    ) u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_adr  (rs1_adr),
        .rs2_adr  (rs2_adr),
        .we       (wb_we),
        .wr_adr   (wb_adr),
        .wr_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    id_ex_reg u_id_ex_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .cmd         (cmd),
        .alu_code    (alu_code),
        .alu_sub     (alu_sub),
        .imm         (imm),
        .rd_adr      (rd_adr),
        .rd_we       (rd_we),
        .rs1_adr     (rs1_adr),
        .rs2_adr     (rs2_adr),
        .rs1_used    (rs1_used),
        .rs2_used    (rs2_used),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .stall       (stall),
        .ex_valid    (ex_valid),
        .ex_cmd      (ex_cmd),
        .ex_alu_code (ex_alu_code),
        .ex_alu_sub  (ex_alu_sub),
        .ex_imm      (ex_imm),
        .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data),
        .ex_rd_adr   (ex_rd_adr),
        .ex_rd_we    (ex_rd_we)
    );

endmodule

// ==== tb_decode_vectors.svh ====
// columns: word, expected command bit, expected imm, rd_we, rs1_used, rs2_used
typedef struct packed {
    inst_t  word;
    int     cmd_bit;
    xword_t imm;
    logic   rd_we;
    logic   rs1_used;
    logic   rs2_used;
} vec_t;

localparam int NUM_VECS = 34;

localparam vec_t VECS [NUM_VECS] = '{
    // lui x5 / auipc x6 / lw x7,-4(x1) / addi x8,x2,2047
    '{32'h123452B7, CMD_LUI,        32'h12345000, 1'b1, 1'b0, 1'b0},
    '{32'hFFFFF317, CMD_AUIPC,      32'hFFFFF000, 1'b1, 1'b0, 1'b0},
    '{32'hFFC0A383, CMD_LD,         32'hFFFFFFFC, 1'b1, 1'b1, 1'b0},
    '{32'h7FF10413, CMD_ALUI,       32'h000007FF, 1'b1, 1'b1, 1'b0},
    // canonical nop
    '{32'h00000013, CMD_NOP,        32'h00000000, 1'b1, 1'b0, 1'b0},
    // slli x9,x3,5 / srai x10,x4,3
    '{32'h00519493, CMD_ALUI_SHAMT, 32'h00000005, 1'b1, 1'b1, 1'b0},
    '{32'h40325513, CMD_ALUI_SHAMT, 32'h00000403, 1'b1, 1'b1, 1'b0},
    // sub x11,x12,x13 / sw x14,8(x15)
    '{32'h40D605B3, CMD_ALU,        32'h00000000, 1'b1, 1'b1, 1'b1},
    '{32'h00E7A423, CMD_ST,         32'h00000008, 1'b0, 1'b1, 1'b1},
    // jal x1,-8 / jalr x1,16(x5) / beq +16 / bne -4
    '{32'hFF9FF0EF, CMD_JAL,        32'hFFFFFFF8, 1'b1, 1'b0, 1'b0},
    '{32'h010280E7, CMD_JALR,       32'h00000010, 1'b1, 1'b1, 1'b0},
    '{32'h00208863, CMD_BR,         32'h00000010, 1'b0, 1'b1, 1'b1},
    '{32'hFE419EE3, CMD_BR,         32'hFFFFFFFC, 1'b0, 1'b1, 1'b1},
    '{32'h0FF0000F, CMD_FENCE,      32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h0000100F, CMD_FENCEI,     32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h12208073, CMD_SFENCE,     32'h00000000, 1'b0, 1'b1, 1'b1},
    // csrrw x5,mstatus,x6 / csrrwi x5,mtvec,7
    '{32'h300312F3, CMD_CSR,        32'h00000300, 1'b1, 1'b1, 1'b0},
    '{32'h3053D2F3, CMD_CSR,        32'h00000305, 1'b1, 1'b0, 1'b0},
    '{32'h00000073, CMD_ECALL,      32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h00100073, CMD_EBREAK,     32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h00200073, CMD_URET,       32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h10200073, CMD_SRET,       32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h30200073, CMD_MRET,       32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h10500073, CMD_WFI,        32'h00000000, 1'b0, 1'b0, 1'b0},
    // malformed: fence rd, fence fm, fence.i imm, ecall rs1, mret rd
    '{32'h0FF0008F, CMD_ILLEGAL,    32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h1FF0000F, CMD_ILLEGAL,    32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h0010100F, CMD_ILLEGAL,    32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h00008073, CMD_ILLEGAL,    32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h302000F3, CMD_ILLEGAL,    32'h00000000, 1'b0, 1'b0, 1'b0},
    // system funct3 100, slli with bit 30, mul, low bits 10, all zero
    '{32'h00004073, CMD_ILLEGAL,    32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h40519493, CMD_ILLEGAL,    32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h02000033, CMD_ILLEGAL,    32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h00000012, CMD_ILLEGAL,    32'h00000000, 1'b0, 1'b0, 1'b0},
    '{32'h00000000, CMD_ILLEGAL,    32'h00000000, 1'b0, 1'b0, 1'b0}
};

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ns

module tb_decode_stage
    import decode_pkg::*;
();

    // longest stall accepted before giving up
    localparam int STALL_LIMIT = 4;

    logic      clk = 1'b0;
    logic      rst_n;
    inst_t     inst;
    logic      inst_valid;
    logic      wb_we;
    reg_adr_t  wb_adr;
    xword_t    wb_data;
    logic      stall;
    logic      ex_valid;
    cmd_vec_t  ex_cmd;
    alu_code_t ex_alu_code;
    logic      ex_alu_sub;
    xword_t    ex_imm;
    xword_t    ex_rs1_data;
    xword_t    ex_rs2_data;
    reg_adr_t  ex_rd_adr;
    logic      ex_rd_we;

    `include "tb_decode_vectors.svh"

    // default WRITE_BYPASS of 1
    decode_stage u_dut (.*);

    always #4 clk = ~clk;

    // rv32i encoders for the directed cases
    function automatic inst_t enc_add(input reg_adr_t rd, input reg_adr_t rs1,
                                      input reg_adr_t rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic inst_t enc_lw(input reg_adr_t rd, input reg_adr_t rs1);
        return {12'h000, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic inst_t enc_sw(input reg_adr_t rs2, input reg_adr_t rs1);
        return {7'b0000000, rs2, rs1, 3'b010, 5'd0, 7'b0100011};
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: %s never happened", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped on timeout");
    endtask

    // nothing valid, random junk on the bus
    task automatic idle_cycle();
        inst_valid = 1'b0;
        inst       = $urandom();
        @(negedge clk);
        expect_eq("ex_valid", ex_valid, 1'b0);
        expect_eq("ex_cmd", ex_cmd, '0);
        expect_eq("ex_rd_we", ex_rd_we, 1'b0);
    endtask

    // drive a word, let the decode settle, look at stall
    task automatic present(input inst_t word, input logic exp_stall);
        inst       = word;
        inst_valid = 1'b1;
        #1;
        expect_eq("stall", stall, exp_stall);
    endtask

    // execute side one edge after the word
    task automatic check_issue(input inst_t word, input int bit_idx);
        expect_eq("ex_valid", ex_valid, 1'b1);
        expect_eq("ex_cmd", ex_cmd, 32'd1 << bit_idx);
        expect_eq("ex_alu_code", ex_alu_code, word[14:12]);
        expect_eq("ex_alu_sub", ex_alu_sub, (bit_idx == CMD_ALU) && word[30]);
        expect_eq("ex_rd_adr", ex_rd_adr, word[11:7]);
    endtask

    task automatic write_reg(input reg_adr_t adr, input xword_t data);
        inst_valid = 1'b0;
        wb_we      = 1'b1;
        wb_adr     = adr;
        wb_data    = data;
        @(negedge clk);
        wb_we      = 1'b0;
    endtask

    initial
    begin
        xword_t v3;
        xword_t v4;
        xword_t v7;
        int     cycles;
        logic   prev_load;
        void'($urandom(32'hef5d96d5));
        rst_n      = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_data    = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        expect_eq("ex_valid", ex_valid, 1'b0);
        expect_eq("ex_cmd", ex_cmd, '0);
        expect_eq("stall", stall, 1'b0);
        repeat (3) idle_cycle();

        // decode table, gap always after a load
        prev_load = 1'b0;
        for (int i = 0; i < NUM_VECS; i++)
        begin
            if (prev_load || ($urandom_range(0, 2) == 0))
                idle_cycle();
            present(VECS[i].word, 1'b0);
            expect_eq("rs1_used", u_dut.rs1_used, VECS[i].rs1_used);
            expect_eq("rs2_used", u_dut.rs2_used, VECS[i].rs2_used);
            @(negedge clk);
            check_issue(VECS[i].word, VECS[i].cmd_bit);
            expect_eq("ex_imm", ex_imm, VECS[i].imm);
            expect_eq("ex_rd_we", ex_rd_we, VECS[i].rd_we);
            prev_load = (VECS[i].cmd_bit == CMD_LD);
        end

        // write then read, x0 write dropped
        idle_cycle();
        v3 = $urandom() | 32'h1;
        v4 = $urandom();
        write_reg(5'd3, v3);
        write_reg(5'd4, v4);
        write_reg(5'd0, $urandom() | 32'h1);
        present(enc_add(5'd5, 5'd3, 5'd4), 1'b0);
        @(negedge clk);
        check_issue(enc_add(5'd5, 5'd3, 5'd4), CMD_ALU);
        expect_eq("ex_rs1_data", ex_rs1_data, v3);
        expect_eq("ex_rs2_data", ex_rs2_data, v4);
        present(enc_add(5'd6, 5'd0, 5'd3), 1'b0);
        @(negedge clk);
        expect_eq("ex_rs1_data", ex_rs1_data, 32'h0);
        expect_eq("ex_rs2_data", ex_rs2_data, v3);

        // x7 written and read in one cycle
        v7      = $urandom() | 32'h1;
        wb_we   = 1'b1;
        wb_adr  = 5'd7;
        wb_data = v7;
        present(enc_add(5'd8, 5'd7, 5'd7), 1'b0);
        @(negedge clk);
        wb_we = 1'b0;
        expect_eq("ex_rs1_data", ex_rs1_data, v7);
        expect_eq("ex_rs2_data", ex_rs2_data, v7);

        // lw x9 then add using x9
        present(enc_lw(5'd9, 5'd3), 1'b0);
        @(negedge clk);
        check_issue(enc_lw(5'd9, 5'd3), CMD_LD);
        present(enc_add(5'd10, 5'd9, 5'd4), 1'b1);
        cycles = 0;
        while (stall)
        begin
            if (cycles == STALL_LIMIT)
                report_timeout("release of stall");
            @(negedge clk);
            // bubble in execute
            expect_eq("ex_valid", ex_valid, 1'b0);
            expect_eq("ex_cmd", ex_cmd, '0);
            expect_eq("ex_rd_we", ex_rd_we, 1'b0);
            cycles++;
            #1;
        end
        expect_eq("stall cycles", cycles, 1);
        @(negedge clk);
        check_issue(enc_add(5'd10, 5'd9, 5'd4), CMD_ALU);
        expect_eq("ex_rs2_data", ex_rs2_data, v4);

        // unrelated store after a load
        present(enc_lw(5'd9, 5'd3), 1'b0);
        @(negedge clk);
        present(enc_sw(5'd12, 5'd13), 1'b0);
        @(negedge clk);
        check_issue(enc_sw(5'd12, 5'd13), CMD_ST);

        // load to x0 then a read of x0
        present(enc_lw(5'd0, 5'd3), 1'b0);
        @(negedge clk);
        check_issue(enc_lw(5'd0, 5'd3), CMD_LD);
        present(enc_add(5'd11, 5'd0, 5'd0), 1'b0);
        @(negedge clk);
        check_issue(enc_add(5'd11, 5'd0, 5'd0), CMD_ALU);
        repeat (2) idle_cycle();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
decode_pkg.sv
decoder.sv
reg_file.sv
id_ex_reg.sv
decode_stage.sv
tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - decode_pkg.sv
  - decoder.sv
  - reg_file.sv
  - id_ex_reg.sv
  - decode_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_decode_stage.sv
